// File: project.f
source/otter_pkg.sv
source/otter_ifs.sv
source/fetch_stage.sv
source/decode_stage.sv
source/execute_stage.sv
source/memory_stage.sv
source/otter_mcu.sv
sim/otter_assertions.sv
sim/otter_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = otter_tb
FILELIST  = project.f
PASS_MSG  = all tests passed

.PHONY: sim clean

# Build, run, then look for the pass message in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: program.mem
// One 32-bit instruction per line in hex, word 0 first
// The trailing comment gives word index and assembly
11000FB7 // 00 lui   x31, 0x11000       I/O base
123450B7 // 01 lui   x1, 0x12345
67808093 // 02 addi  x1, x1, 0x678
001FA023 // 03 sw    x1, 0(x31)         entry 0
F9C00113 // 04 addi  x2, x0, -100
02500193 // 05 addi  x3, x0, 37
00310233 // 06 add   x4, x2, x3
403202B3 // 07 sub   x5, x4, x3
0032C333 // 08 xor   x6, x5, x3
00431393 // 09 slli  x7, x6, 4
0033A433 // 10 slt   x8, x7, x3
0083B4B3 // 11 sltu  x9, x7, x8
004FA223 // 12 sw    x4, 4(x31)         entry 1
005FA423 // 13 sw    x5, 8(x31)         entry 2
006FA623 // 14 sw    x6, 12(x31)        entry 3
007FA823 // 15 sw    x7, 16(x31)        entry 4
008FAA23 // 16 sw    x8, 20(x31)        entry 5
009FAC23 // 17 sw    x9, 24(x31)        entry 6
000FA503 // 18 lw    x10, 0(x31)        read iobus_in
00150593 // 19 addi  x11, x10, 1        load-use stall
00BFAE23 // 20 sw    x11, 28(x31)       entry 7
FFF54613 // 21 xori  x12, x10, -1
02CFA023 // 22 sw    x12, 32(x31)       entry 8
CAFE06B7 // 23 lui   x13, 0xCAFE0
00168693 // 24 addi  x13, x13, 1
04D02023 // 25 sw    x13, 0x40(x0)      RAM
04002703 // 26 lw    x14, 0x40(x0)
00270793 // 27 addi  x15, x14, 2
02FFA223 // 28 sw    x15, 36(x31)       entry 9
00000813 // 29 addi  x16, x0, 0         sum
00500893 // 30 addi  x17, x0, 5         counter
01180833 // 31 add   x16, x16, x17      loop top
FFF88893 // 32 addi  x17, x17, -1
FE089CE3 // 33 bne   x17, x0, -8
030FA423 // 34 sw    x16, 40(x31)       entry 10
7FF00913 // 35 addi  x18, x0, 2047
3AE90913 // 36 addi  x18, x18, 942      x18 = 0xBAD
05A00993 // 37 addi  x19, x0, 0x5A
00088663 // 38 beq   x17, x0, +12       taken
032FA623 // 39 sw    x18, 44(x31)       flushed
032FA623 // 40 sw    x18, 44(x31)       flushed
033FA623 // 41 sw    x19, 44(x31)       entry 11
03C00A13 // 42 addi  x20, x0, 0x3C
00315463 // 43 bge   x2, x3, +8         not taken
034FA823 // 44 sw    x20, 48(x31)       entry 12
00C00AEF // 45 jal   x21, +12           link 0xB8
032FAA23 // 46 sw    x18, 52(x31)       flushed
032FAA23 // 47 sw    x18, 52(x31)       flushed
035FAA23 // 48 sw    x21, 52(x31)       entry 13
00000B17 // 49 auipc x22, 0             x22 = 0xC4
015B0067 // 50 jalr  x0, 21(x22)        to word 54
032FAC23 // 51 sw    x18, 56(x31)       skipped
032FAC23 // 52 sw    x18, 56(x31)       skipped
032FAC23 // 53 sw    x18, 56(x31)       skipped
07700B93 // 54 addi  x23, x0, 0x77
037FAC23 // 55 sw    x23, 56(x31)       entry 14
0000006F // 56 jal   x0, 0              self-loop

// File: sim/otter_tb.sv
`timescale 1ns/10ps

module otter_tb import otter_pkg::*; ();

    localparam int NUM_WRITES   = 15;  // Entries in the expected-write table
    localparam int CLK_PERIOD   = 40;
    localparam int QUIET_CYCLES = 50;  // Bus stays idle after the last entry

    logic  CLK;
    logic  arst_n;
    word_t iobus_in;
    word_t iobus_out;
    word_t iobus_addr;
    logic  iobus_wr;

    word_t exp_addr [NUM_WRITES];
    word_t exp_data [NUM_WRITES];
    string exp_name [NUM_WRITES];
    word_t rnd;       // Value held on iobus_in
    int    errors;
    int    passed;

    otter_mcu dut_i (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .iobus_in   (iobus_in),
        .iobus_out  (iobus_out),
        .iobus_addr (iobus_addr),
        .iobus_wr   (iobus_wr)
    );

    always #(CLK_PERIOD / 2) CLK = ~CLK;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    function automatic word_t xorshift(word_t s);
        word_t x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Entry n lands at IO_BASE + 4n
    task automatic set_entry(input int idx, input word_t data, input string name);
        exp_addr[idx] = IO_BASE + word_t'(4 * idx);
        exp_data[idx] = data;
        exp_name[idx] = name;
    endtask

    task automatic build_table(input word_t bus_val);
        int a;
        int b;
        int r_add;
        int r_sub;
        int r_xor;
        int r_sll;
        int r_slt;
        int r_sltu;
        int sum;
        a      = -100;
        b      = 37;
        r_add  = a + b;
        r_sub  = r_add - b;
        r_xor  = r_sub ^ b;
        r_sll  = r_xor << 4;
        r_slt  = (r_sll < b) ? 1 : 0;                              // Signed compare
        r_sltu = (word_t'(r_sll) < word_t'(r_slt)) ? 1 : 0;         // Unsigned compare
        sum    = 0;
        for (int k = 1; k <= 5; k++)
            sum += k;
        set_entry(0, 32'h1234_5000 + 32'h678, "lui_addi");
        set_entry(1, r_add, "add");
        set_entry(2, r_sub, "sub");
        set_entry(3, r_xor, "xor");
        set_entry(4, r_sll, "sll");
        set_entry(5, r_slt, "slt");
        set_entry(6, r_sltu, "sltu");
        set_entry(7, bus_val + 32'd1, "load_use");
        set_entry(8, bus_val ^ 32'hFFFF_FFFF, "load_xor");
        set_entry(9, 32'hCAFE_0001 + 32'd2, "ram_round_trip");
        set_entry(10, sum, "bne_loop");
        set_entry(11, 32'h5A, "beq_taken");
        set_entry(12, 32'h3C, "bge_not_taken");
        set_entry(13, 32'h0000_00B4 + 32'd4, "jal_link");  // JAL sits at byte 0xB4
        set_entry(14, 32'h77, "jalr_target");
    endtask

    task automatic compare_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at time %0t: %s data %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic compare_addr(input word_t got, input word_t exp, input string what);
        if (got !== exp)
        begin
            errors++;
            $display("mismatch at time %0t: %s address %h, expected %h",
                     $time, what, got, exp);
        end
    endtask

    // Strobe lasts one full cycle, so the falling edge sees it settled
    task automatic wait_for_write();
        @(negedge CLK);
        while (iobus_wr !== 1'b1)
            @(negedge CLK);
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial
    begin : run
        int first_err;
        CLK      = 1'b0;
        arst_n   = 1'b0;
        iobus_in = '0;
        errors   = 0;
        passed   = 0;
        rnd      = xorshift(32'd76);
        build_table(rnd);
        repeat (4) @(posedge CLK);
        @(negedge CLK);
        arst_n   = 1'b1;
        iobus_in = rnd;   // Held for the whole run

        for (int i = 0; i < NUM_WRITES; i++)
        begin
            first_err = errors;
            wait_for_write();
            compare_addr(iobus_addr, exp_addr[i], exp_name[i]);
            compare_word(iobus_out, exp_data[i], exp_name[i]);
            if (errors == first_err)
            begin
                passed++;
                $display("test %0d %s: ok", i, exp_name[i]);
            end
            else
                $display("test %0d %s: failed", i, exp_name[i]);
        end

        // Nothing may reach the bus once the program parks in its loop
        first_err = errors;
        repeat (QUIET_CYCLES)
        begin
            @(negedge CLK);
            if (iobus_wr === 1'b1)
            begin
                errors++;
                $display("unexpected bus write at time %0t to address %h, data %h",
                         $time, iobus_addr, iobus_out);
            end
        end
        if (errors == first_err)
        begin
            passed++;
            $display("test %0d idle_bus: ok", NUM_WRITES);
        end
        else
            $display("test %0d idle_bus: failed", NUM_WRITES);

        $display("%0d of %0d tests passed, %0d errors", passed, NUM_WRITES + 1, errors);
        if (errors == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

    // Watchdog with a generous budget per expected write
    initial
    begin
        #(NUM_WRITES * 200 * CLK_PERIOD);
        $display("timeout: the expected bus writes did not all appear");
        $display("tests failed");
        $finish;
    end

endmodule

// File: sim/otter_assertions.sv
`timescale 1ns/10ps

// I/O bus checks on the top level
module otter_assertions import otter_pkg::*; (
    input logic  CLK,
    input logic  arst_n,
    input logic  iobus_wr,
    input word_t iobus_addr
);

    // No strobe while the core is held in reset
    wr_low_in_reset: assert property (@(posedge CLK) !arst_n |-> !iobus_wr)
        else $error("iobus_wr high during reset");

    wr_known: assert property (@(posedge CLK) !$isunknown(iobus_wr))
        else $error("iobus_wr is unknown");

    // Writes go to whole aligned words
    wr_addr_ok: assert property (@(posedge CLK) disable iff (!arst_n)
        iobus_wr |-> iobus_addr[1:0] == 2'b00)
        else $error("bus write to bad address %h", iobus_addr);

endmodule

bind otter_mcu otter_assertions assert_i (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .iobus_wr   (iobus_wr),
    .iobus_addr (iobus_addr)
);

// File: source/otter_mcu.sv
`timescale 1ns/10ps

module otter_mcu import otter_pkg::*; #(
    parameter int IMEM_WORDS = 64,   // Instruction ROM depth in words
    parameter int DMEM_WORDS = 256   // Data RAM depth in words
) (
    input  logic  CLK,
    input  logic  arst_n,
    input  word_t iobus_in,
    output word_t iobus_out,
    output word_t iobus_addr,
    output logic  iobus_wr
);

    ////////////////////////////////////////////////////////////
    // Inter-stage wires
    ////////////////////////////////////////////////////////////

    word_t     if_instr;     // Fetch/decode register
    word_t     if_pc;
    logic      if_valid;
    logic      stall;        // Load-use hold from decode
    logic      redirect;     // Jump or taken branch in execute
    word_t     redirect_pc;
    ex_ctrl_t  ex_ctrl;      // Decode/execute register
    word_t     ex_rs1;
    word_t     ex_rs2;
    word_t     ex_imm;
    ex_ctrl_t  mem_ctrl;     // Execute/memory register
    word_t     alu_result;
    word_t     store_data;
    logic      rf_we;        // Writeback port of the register file
    reg_addr_t rf_rd;
    word_t     rf_data;

    fwd_if fwd ();

    fetch_stage #(
        .IMEM_WORDS (IMEM_WORDS)
    ) fetch_i (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .instr       (if_instr),
        .pc          (if_pc),
        .valid       (if_valid)
    );

    decode_stage decode_i (
        .CLK      (CLK),
        .arst_n   (arst_n),
        .instr    (if_instr),
        .pc       (if_pc),
        .valid    (if_valid),
        .redirect (redirect),
        .hz       (fwd.hazard),
        .rf_we    (rf_we),
        .rf_rd    (rf_rd),
        .rf_data  (rf_data),
        .stall    (stall),
        .ctrl     (ex_ctrl),
        .rs1_val  (ex_rs1),
        .rs2_val  (ex_rs2),
        .imm      (ex_imm)
    );

    execute_stage execute_i (
        .CLK         (CLK),
        .arst_n      (arst_n),
        .ctrl        (ex_ctrl),
        .rs1_val     (ex_rs1),
        .rs2_val     (ex_rs2),
        .imm         (ex_imm),
        .fw          (fwd.sink),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .mem_ctrl    (mem_ctrl),
        .alu_result  (alu_result),
        .store_data  (store_data)
    );

    memory_stage #(
        .DMEM_WORDS (DMEM_WORDS)
    ) memory_i (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .mem_ctrl   (mem_ctrl),
        .alu_result (alu_result),
        .store_data (store_data),
        .iobus_in   (iobus_in),
        .fw         (fwd.source),
        .rf_we      (rf_we),
        .rf_rd      (rf_rd),
        .rf_data    (rf_data),
        .iobus_out  (iobus_out),
        .iobus_addr (iobus_addr),
        .iobus_wr   (iobus_wr)
    );

endmodule

// File: source/memory_stage.sv
`timescale 1ns/10ps

module memory_stage import otter_pkg::*; #(
    parameter int DMEM_WORDS = 256
) (
    input  logic      CLK,
    input  logic      arst_n,
    input  ex_ctrl_t  mem_ctrl,
    input  word_t     alu_result,
    input  word_t     store_data,
    input  word_t     iobus_in,
    fwd_if.source     fw,
    output logic      rf_we,
    output reg_addr_t rf_rd,
    output word_t     rf_data,
    output word_t     iobus_out,
    output word_t     iobus_addr,
    output logic      iobus_wr
);

    localparam int DA_W = $clog2(DMEM_WORDS);  // RAM word index width

    word_t ram [DMEM_WORDS];
    logic  is_io;       // Address falls in the MMIO region
    logic  st_en;       // Valid store in this stage
    word_t mem_res;     // Value this stage would write back
    word_t ram_q;       // Synchronous RAM read
    word_t io_q;        // Bus input sampled with the RAM read
    word_t wb_val;      // ALU or link value in writeback
    logic  wb_from_io;
    logic  wb_load;

    assign is_io   = alu_result >= IO_BASE;
    assign st_en   = mem_ctrl.valid && mem_ctrl.mem_we;
    assign mem_res = (mem_ctrl.wb_sel == WB_PC4) ? mem_ctrl.pc + 32'd4 : alu_result;

    // MMIO bus with a one-cycle write strobe
    assign iobus_wr   = st_en && is_io;
    assign iobus_addr = alu_result;
    assign iobus_out  = store_data;

    ////////////////////////////////////////////////////////////
    // Data RAM and memory/writeback register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (st_en && !is_io)
            ram[alu_result[DA_W+1:2]] <= store_data;
        ram_q      <= ram[alu_result[DA_W+1:2]];
        io_q       <= iobus_in;
        wb_val     <= mem_res;
        wb_from_io <= is_io;
        rf_rd      <= mem_ctrl.rd;
    end

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
        begin
            rf_we   <= 1'b0;
            wb_load <= 1'b0;
        end
        else
        begin
            rf_we   <= mem_ctrl.valid && mem_ctrl.reg_we;
            wb_load <= mem_ctrl.valid && mem_ctrl.wb_sel == WB_LOAD;
        end
    end

    // Load data replaces the registered ALU or link value
    assign rf_data = wb_load ? (wb_from_io ? io_q : ram_q) : wb_val;

    ////////////////////////////////////////////////////////////
    // Forwarding sources
    ////////////////////////////////////////////////////////////

    assign fw.mem_rd     = mem_ctrl.rd;
    assign fw.mem_we     = mem_ctrl.valid && mem_ctrl.reg_we && !mem_ctrl.mem_re;
    assign fw.mem_result = mem_res;   // Load data not ready here
    assign fw.wb_rd      = rf_rd;
    assign fw.wb_we      = rf_we;
    assign fw.wb_result  = rf_data;
    assign fw.wb_is_load = wb_load;

endmodule

// File: source/execute_stage.sv
`timescale 1ns/10ps

module execute_stage import otter_pkg::*; (
    input  logic     CLK,
    input  logic     arst_n,
    input  ex_ctrl_t ctrl,
    input  word_t    rs1_val,
    input  word_t    rs2_val,
    input  word_t    imm,
    fwd_if.sink      fw,
    output logic     redirect,
    output word_t    redirect_pc,
    output ex_ctrl_t mem_ctrl,
    output word_t    alu_result,
    output word_t    store_data
);

    word_t rs1_f;     // Operands after forwarding
    word_t rs2_f;
    word_t opa;       // ALU inputs
    word_t opb;
    word_t alu_out;
    logic  br_eq;
    logic  br_lt;
    logic  br_ltu;
    logic  br_taken;

    // Youngest producer wins and x0 is never forwarded
    function automatic word_t forward(reg_addr_t rs, word_t dec_val);
        if (rs == '0)
            return dec_val;
        else if (fw.mem_we && fw.mem_rd == rs)
            return fw.mem_result;
        else if (fw.wb_we && fw.wb_rd == rs)
            return fw.wb_result;
        else
            return dec_val;
    endfunction

    // Tell decode what sits here for load-use detection
    assign fw.ex_rd      = ctrl.rd;
    assign fw.ex_is_load = ctrl.valid && ctrl.mem_re;

    assign rs1_f = forward(ctrl.rs1, rs1_val);
    assign rs2_f = forward(ctrl.rs2, rs2_val);
    assign opa   = (ctrl.opcode == AUIPC) ? ctrl.pc : rs1_f;
    assign opb   = (ctrl.opcode == OP) ? rs2_f : imm;  // Immediate for the rest

    ////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_ADD:  alu_out = opa + opb;
            ALU_SUB:  alu_out = opa - opb;
            ALU_SLL:  alu_out = opa << opb[4:0];
            ALU_SLT:  alu_out = {31'd0, $signed(opa) < $signed(opb)};
            ALU_SLTU: alu_out = {31'd0, opa < opb};
            ALU_XOR:  alu_out = opa ^ opb;
            ALU_SRL:  alu_out = opa >> opb[4:0];
            ALU_SRA:  alu_out = $signed(opa) >>> opb[4:0];
            ALU_OR:   alu_out = opa | opb;
            ALU_AND:  alu_out = opa & opb;
            ALU_LUI:  alu_out = opb;
            default:  alu_out = opa + opb;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Branch decision and targets
    ////////////////////////////////////////////////////////////

    assign br_eq  = rs1_f == rs2_f;
    assign br_lt  = $signed(rs1_f) < $signed(rs2_f);
    assign br_ltu = rs1_f < rs2_f;

    always_comb
    begin
        case (ctrl.funct3)
            3'b000:  br_taken = br_eq;    // BEQ
            3'b001:  br_taken = !br_eq;   // BNE
            3'b100:  br_taken = br_lt;    // BLT
            3'b101:  br_taken = !br_lt;   // BGE
            3'b110:  br_taken = br_ltu;   // BLTU
            3'b111:  br_taken = !br_ltu;  // BGEU
            default: br_taken = 1'b0;
        endcase
    end

    assign redirect = ctrl.valid &&
                      (ctrl.opcode == JAL || ctrl.opcode == JALR ||
                       (ctrl.opcode == BRANCH && br_taken));

    // JALR drops bit 0 of its target
    assign redirect_pc = (ctrl.opcode == JALR) ? ((rs1_f + imm) & ~32'd1)
                                               : ctrl.pc + imm;

    ////////////////////////////////////////////////////////////
    // Execute/memory register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
            mem_ctrl <= '0;
        else
            mem_ctrl <= ctrl;
    end

    always_ff @(posedge CLK)
    begin
        alu_result <= alu_out;
        store_data <= rs2_f;      // Forwarded value for stores
    end

endmodule

// File: source/decode_stage.sv
`timescale 1ns/10ps

module decode_stage import otter_pkg::*; (
    input  logic      CLK,
    input  logic      arst_n,
    input  word_t     instr,
    input  word_t     pc,
    input  logic      valid,
    input  logic      redirect,
    fwd_if.hazard     hz,
    input  logic      rf_we,
    input  reg_addr_t rf_rd,
    input  word_t     rf_data,
    output logic      stall,
    output ex_ctrl_t  ctrl,
    output word_t     rs1_val,
    output word_t     rs2_val,
    output word_t     imm
);

    word_t     regs [32];  // Register file where x0 is never written
    opcode_t   opcode;
    reg_addr_t rs1;
    reg_addr_t rs2;
    ex_ctrl_t  dec;        // Decoded control for this instruction
    word_t     dec_imm;

    assign opcode = opcode_t'(instr[6:0]);
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    // Same-cycle writeback is passed straight through
    function automatic word_t rf_read(reg_addr_t a);
        if (a == '0)
            return '0;
        else if (rf_we && rf_rd == a)
            return rf_data;
        else
            return regs[a];
    endfunction

    ////////////////////////////////////////////////////////////
    // Decoder and immediates
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        dec        = '0;
        dec.opcode = opcode;
        dec.funct3 = instr[14:12];
        dec.rd     = instr[11:7];
        dec.rs1    = rs1;
        dec.rs2    = rs2;
        dec.alu_op = ALU_ADD;
        dec.wb_sel = WB_ALU;
        dec.pc     = pc;
        dec.valid  = valid;
        dec_imm    = {{20{instr[31]}}, instr[31:20]};  // I-type by default
        case (opcode)
            LUI:
            begin
                dec.reg_we = 1'b1;
                dec.alu_op = ALU_LUI;
                dec_imm    = {instr[31:12], 12'h000};
            end
            AUIPC:
            begin
                dec.reg_we = 1'b1;                       // PC + U-imm in execute
                dec_imm    = {instr[31:12], 12'h000};
            end
            OP:
            begin
                dec.rs1_used = 1'b1;
                dec.rs2_used = 1'b1;
                dec.reg_we   = 1'b1;
                dec.alu_op   = alu_op_t'({instr[30], instr[14:12]});
            end
            OP_IMM:
            begin
                dec.rs1_used = 1'b1;
                dec.reg_we   = 1'b1;
                // Only SRAI takes bit 30; ADDI has no subtract form
                dec.alu_op   = alu_op_t'({instr[14:12] == 3'b101 && instr[30],
                                          instr[14:12]});
            end
            LOAD:
            begin
                dec.rs1_used = 1'b1;
                dec.reg_we   = 1'b1;
                dec.mem_re   = 1'b1;
                dec.wb_sel   = WB_LOAD;
            end
            STORE:
            begin
                dec.rs1_used = 1'b1;
                dec.rs2_used = 1'b1;
                dec.mem_we   = 1'b1;
                dec_imm      = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            end
            BRANCH:
            begin
                dec.rs1_used = 1'b1;
                dec.rs2_used = 1'b1;
                dec_imm      = {{20{instr[31]}}, instr[7], instr[30:25],
                                instr[11:8], 1'b0};
            end
            JAL:
            begin
                dec.reg_we = 1'b1;
                dec.wb_sel = WB_PC4;
                dec_imm    = {{12{instr[31]}}, instr[19:12], instr[20],
                              instr[30:21], 1'b0};
            end
            JALR:
            begin
                dec.rs1_used = 1'b1;
                dec.reg_we   = 1'b1;
                dec.wb_sel   = WB_PC4;
            end
            default: dec.valid = 1'b0;  // Unsupported opcode becomes a bubble
        endcase
    end

    // Load in execute feeding a source of this instruction
    assign stall = dec.valid && hz.ex_is_load && hz.ex_rd != '0 &&
                   ((dec.rs1_used && rs1 == hz.ex_rd) ||
                    (dec.rs2_used && rs2 == hz.ex_rd));

    ////////////////////////////////////////////////////////////
    // Register file and decode/execute register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK)
    begin
        if (rf_we && rf_rd != '0)
            regs[rf_rd] <= rf_data;
    end

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
            ctrl <= '0;
        else if (stall || redirect)
            ctrl <= '0;                 // Bubble into execute
        else
            ctrl <= dec;
    end

    always_ff @(posedge CLK)
    begin
        rs1_val <= rf_read(rs1);
        rs2_val <= rf_read(rs2);
        imm     <= dec_imm;
    end

endmodule

// File: source/fetch_stage.sv
`timescale 1ns/10ps

module fetch_stage import otter_pkg::*; #(
    parameter int IMEM_WORDS = 64
) (
    input  logic  CLK,
    input  logic  arst_n,
    input  logic  stall,
    input  logic  redirect,
    input  word_t redirect_pc,
    output word_t instr,
    output word_t pc,
    output logic  valid
);

    localparam int IA_W = $clog2(IMEM_WORDS);  // ROM word index width

    word_t rom [IMEM_WORDS];  // Word-addressed program store
    word_t fetch_pc;          // PC of the instruction being read now

    initial
    begin
        $readmemh("program.mem", rom);
    end

    // Redirect wins; a load-use stall holds the PC in place
    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
            fetch_pc <= '0;
        else if (redirect)
            fetch_pc <= redirect_pc;
        else if (!stall)
            fetch_pc <= fetch_pc + 32'd4;
    end

    ////////////////////////////////////////////////////////////
    // Fetch/decode register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge CLK or negedge arst_n)
    begin
        if (!arst_n)
            valid <= 1'b0;
        else if (redirect)
            valid <= 1'b0;              // Wrong-path slot
        else if (!stall)
            valid <= 1'b1;
    end

    always_ff @(posedge CLK)
    begin
        if (!stall)
        begin
            instr <= rom[fetch_pc[IA_W+1:2]];  // Byte PC to word index
            pc    <= fetch_pc;
        end
    end

endmodule

// File: source/otter_ifs.sv
`timescale 1ns/10ps

// Forwarding and hazard signals between the later stages and execute
interface fwd_if import otter_pkg::*; ();

    reg_addr_t mem_rd;      // Destination of the instruction in memory
    logic      mem_we;      // Memory-stage result can be forwarded
    word_t     mem_result;
    reg_addr_t wb_rd;       // Destination of the instruction in writeback
    logic      wb_we;
    word_t     wb_result;   // Final register write data
    logic      wb_is_load;  // Writeback value comes from RAM or the bus
    reg_addr_t ex_rd;       // Destination of the instruction in execute
    logic      ex_is_load;  // Valid load sitting in execute

    modport source (
        output mem_rd, mem_we, mem_result,
        output wb_rd, wb_we, wb_result, wb_is_load
    );

    modport sink (
        input  mem_rd, mem_we, mem_result,
        input  wb_rd, wb_we, wb_result,
        output ex_rd, ex_is_load
    );

    modport hazard (
        input ex_rd, ex_is_load
    );

endinterface

// File: source/otter_pkg.sv
package otter_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    typedef logic [31:0] word_t;      // Data or byte address
    typedef logic [4:0]  reg_addr_t;  // Register number x0..x31

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        NOP    = 7'b0000000,  // Bubble
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        JAL    = 7'b1101111,
        JALR   = 7'b1100111,
        BRANCH = 7'b1100011,
        LOAD   = 7'b0000011,
        STORE  = 7'b0100011,
        OP_IMM = 7'b0010011,
        OP     = 7'b0110011
    } opcode_t;

    // Encoded as {funct7[5], funct3} so OP decodes directly
    typedef enum logic [3:0] {
        ALU_ADD  = 4'b0000,
        ALU_SUB  = 4'b1000,
        ALU_SLL  = 4'b0001,
        ALU_SLT  = 4'b0010,
        ALU_SLTU = 4'b0011,
        ALU_XOR  = 4'b0100,
        ALU_SRL  = 4'b0101,
        ALU_SRA  = 4'b1101,
        ALU_OR   = 4'b0110,
        ALU_AND  = 4'b0111,
        ALU_LUI  = 4'b1001   // Pass operand B
    } alu_op_t;

    typedef enum logic [1:0] {
        WB_ALU  = 2'd0,
        WB_LOAD = 2'd1,
        WB_PC4  = 2'd2       // Link value for JAL/JALR
    } wb_sel_t;

    // Control word that follows an instruction from decode onward
    typedef struct packed {
        opcode_t   opcode;
        logic [2:0] funct3;   // Branch condition
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      rs1_used;
        logic      rs2_used;
        logic      reg_we;
        logic      mem_we;
        logic      mem_re;
        alu_op_t   alu_op;
        wb_sel_t   wb_sel;
        word_t     pc;
        logic      valid;     // Cleared for bubbles and flushed slots
    } ex_ctrl_t;

    localparam word_t IO_BASE = 32'h1100_0000;  // Start of the MMIO region

endpackage
